// File: project.f
exec_pkg.sv
exec_int.sv
exec_branch.sv
exec_mem.sv
load_store.sv
data_ram.sv
exec.sv
exec_top.sv
tb_exec.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exec
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The simulator exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec import exec_pkg::*; ();

    typedef struct packed {
        logic chain; // Offered in the result cycle of the entry before
        logic [4:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic is_jump;
        logic is_wr;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic dec_exc;
        logic [3:0] dec_cause;
        logic [31:0] exp_result;
        logic [31:0] exp_target;
        logic exp_wr;
        logic exp_exc;
        logic [3:0] exp_cause;
        logic exp_taken;
        logic [3:0] lat;
    } entry_t;

    logic clk, rst, prev_stalled, stall_prev, stall_next;
    logic decode_exception, decode_is_jump, decode_is_reg_write;
    logic [3:0] decode_trap_cause;
    logic [31:0] decode_instruction_addr, decode_instruction_next_addr;
    logic [4:0] opcode, rd, rs1, rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] decode_rs1_data, decode_rs2_data;
    logic [11:0] i_imm, s_imm, b_imm;
    logic [19:0] u_imm, j_imm;
    logic exec_exception, exec_is_taken_branch, exec_is_reg_write, exec_pipeline_flush;
    logic [3:0] exec_trap_cause;
    logic [4:0] exec_reg_write_sel;
    logic [31:0] exec_result, exec_branch_target, exec_instruction_next_addr;

    entry_t tests[$];
    string names[$];
    entry_t cur;
    string cur_name;
    logic [7:0] mem_model [0:4*ram_words-1]; // Byte image of data_ram
    int cycles = 0;
    int max_cycles = 0;

    exec_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (max_cycles > 0 && cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic start_entry(input string name, input logic [4:0] op, input logic [2:0] f3,
            input logic [4:0] dst, input logic [31:0] a, input logic [31:0] b,
            input logic [31:0] imm);
        cur = '0;
        cur_name = name;
        cur.opcode = op;
        cur.funct3 = f3;
        cur.rd = dst;
        cur.rs1 = 5'd10;
        cur.rs2 = 5'd11;
        cur.a = a;
        cur.b = b;
        cur.imm = imm;
        cur.pc = 32'h100 + 32'(tests.size() * 4);
        cur.is_jump = (op == op_jal) || (op == op_jalr);
        cur.is_wr = (op != op_store) && (op != op_branch);
        cur.lat = 4'd1;
    endtask

    task automatic push_entry();
        tests.push_back(cur);
        names.push_back(cur_name);
    endtask

    task automatic expect_write(input logic [31:0] value);
        cur.exp_wr = cur.rd != 5'd0; // x0 is never written
        cur.exp_result = value;
        push_entry();
    endtask

    task automatic expect_taken(input logic [31:0] target);
        cur.exp_taken = 1'b1;
        cur.exp_target = target;
        push_entry();
    endtask

    task automatic expect_trap(input logic [3:0] cause, input logic [3:0] lat);
        cur.exp_exc = 1'b1;
        cur.exp_cause = cause;
        cur.lat = lat;
        push_entry();
    endtask

    // Base register points 16 bytes below the access
    task automatic mem_entry(input string name, input logic [4:0] op, input logic [2:0] f3,
            input logic [31:0] addr, input logic [31:0] data);
        start_entry(name, op, f3, (op == op_load) ? 5'd8 : 5'd0, addr - 32'd16, data, 32'd16);
        cur.lat = 4'd3;
    endtask

    task automatic model_store(input logic [2:0] f3, input logic [31:0] addr,
            input logic [31:0] data);
        for (int k = 0; k < (1 << f3[1:0]); k++) begin
            mem_model[addr + k] = data[k*8 +: 8];
        end
    endtask

    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        w = {mem_model[addr + 3], mem_model[addr + 2], mem_model[addr + 1], mem_model[addr]};
        case (f3)
            f3_byte: return {{24{w[7]}}, w[7:0]};
            f3_byte_u: return {24'b0, w[7:0]};
            f3_half: return {{16{w[15]}}, w[15:0]};
            f3_half_u: return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic build_table();
        logic [31:0] a, b, r, imm;
        a = $urandom();
        b = $urandom();
        start_entry("add", op_op, 3'b000, 5'd5, a, b, 0);
        expect_write(a + b);
        start_entry("sub", op_op, 3'b000, 5'd5, a, b, 0);
        cur.funct7 = 7'h20;
        expect_write(a - b);
        a = $urandom() | 32'h8000_0000;
        start_entry("sra", op_op, 3'b101, 5'd6, a, b, 0);
        cur.funct7 = 7'h20;
        // Negative operand, so the vacated high bits fill with ones
        expect_write((a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]));
        a = $urandom();
        b = $urandom();
        start_entry("sltu", op_op, 3'b011, 5'd6, a, b, 0);
        expect_write({31'b0, a < b});
        start_entry("xor", op_op, 3'b100, 5'd7, a, b, 0);
        expect_write(a ^ b);
        r = $urandom();
        imm = {r[31:12], 12'b0};
        start_entry("lui", op_lui, 3'b000, 5'd8, 0, 0, imm);
        expect_write(imm);
        start_entry("auipc", op_auipc, 3'b000, 5'd9, 0, 0, imm);
        expect_write(cur.pc + imm);
        start_entry("add_x0", op_op, 3'b000, 5'd0, a, b, 0);
        expect_write(a + b);

        // Consumer reads x7 in the cycle the producer's result leaves
        imm = {{20{r[11]}}, r[11:0]};
        start_entry("addi_producer", op_op_imm, 3'b000, 5'd7, a, 0, imm);
        expect_write(a + imm);
        start_entry("add_bypass", op_op, 3'b000, 5'd9, $urandom(), b, 0);
        cur.rs1 = 5'd7;
        cur.chain = 1'b1;
        expect_write(a + imm + b);

        start_entry("beq_not_taken", op_branch, f3_beq, 5'd0, a, a ^ 32'h1, 32'h40);
        push_entry();
        a = $urandom() | 32'h8000_0000;
        b = $urandom() & 32'h7fff_ffff;
        start_entry("blt_taken", op_branch, f3_blt, 5'd0, a, b, 32'h40);
        expect_taken(cur.pc + 32'h40);
        start_entry("jal", op_jal, 3'b000, 5'd1, 0, 0, 32'hffff_fff0);
        cur.exp_wr = 1'b1;
        cur.exp_result = cur.pc + 32'd4;
        expect_taken(cur.pc - 32'd16);
        start_entry("add_in_flush", op_op, 3'b000, 5'd6, a, b, 0);
        cur.chain = 1'b1;
        push_entry();

        a = $urandom();
        mem_entry("sw", op_store, f3_word, 32'h40, a);
        model_store(f3_word, 32'h40, a);
        push_entry();
        b = $urandom() | 32'h8000;
        mem_entry("sh", op_store, f3_half, 32'h42, b);
        model_store(f3_half, 32'h42, b);
        push_entry();
        r = $urandom() | 32'h80;
        mem_entry("sb", op_store, f3_byte, 32'h41, r);
        model_store(f3_byte, 32'h41, r);
        push_entry();
        mem_entry("lb", op_load, f3_byte, 32'h41, 0);
        expect_write(load_value(f3_byte, 32'h41));
        mem_entry("lbu", op_load, f3_byte_u, 32'h43, 0);
        expect_write(load_value(f3_byte_u, 32'h43));
        mem_entry("lh", op_load, f3_half, 32'h42, 0);
        expect_write(load_value(f3_half, 32'h42));
        mem_entry("lhu", op_load, f3_half_u, 32'h40, 0);
        expect_write(load_value(f3_half_u, 32'h40));
        mem_entry("lw", op_load, f3_word, 32'h40, 0);
        expect_write(load_value(f3_word, 32'h40));

        mem_entry("lh_misaligned", op_load, f3_half, 32'h45, 0);
        expect_trap(cause_load_misaligned, 4'd1);
        mem_entry("sw_misaligned", op_store, f3_word, 32'h42, $urandom());
        expect_trap(cause_store_misaligned, 4'd1);
        mem_entry("lw_fault", op_load, f3_word, 32'(ram_words * 4), 0);
        expect_trap(cause_load_fault, 4'd2);
        mem_entry("sb_fault", op_store, f3_byte, 32'h1000, $urandom());
        expect_trap(cause_store_fault, 4'd2);
        start_entry("jalr_misaligned", op_jalr, 3'b000, 5'd1, 32'h202, 0, 0);
        expect_trap(cause_instr_misaligned, 4'd1);
        start_entry("decode_exception", op_op, 3'b000, 5'd3, a, b, 0);
        cur.dec_exc = 1'b1;
        cur.dec_cause = cause_illegal;
        expect_trap(cause_illegal, 4'd1);
    endtask

    task automatic drive_entry(input int i);
        entry_t e;
        e = tests[i];
        prev_stalled <= 1'b0;
        opcode <= e.opcode;
        funct3 <= e.funct3;
        funct7 <= e.funct7;
        rd <= e.rd;
        rs1 <= e.rs1;
        rs2 <= e.rs2;
        decode_rs1_data <= e.a;
        decode_rs2_data <= e.b;
        i_imm <= e.imm[11:0];
        s_imm <= e.imm[11:0];
        b_imm <= e.imm[12:1];
        u_imm <= e.imm[31:12];
        j_imm <= e.imm[20:1];
        decode_is_jump <= e.is_jump;
        decode_is_reg_write <= e.is_wr;
        decode_instruction_addr <= e.pc;
        decode_instruction_next_addr <= e.pc + 32'd4;
        decode_exception <= e.dec_exc;
        decode_trap_cause <= e.dec_cause;
    endtask

    task automatic check_value(input string name, input string field, input logic [31:0] exp,
            input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s %s: expected 0x%08h, actual 0x%08h", name, field, exp, act);
            $display("Checks failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_entry(input int i, input int lat);
        entry_t e;
        logic discarded;
        e = tests[i];
        // Offered in the flush cycle of the entry before, so it never enters the stage
        discarded = e.chain && i > 0 && (tests[i - 1].exp_taken || tests[i - 1].exp_exc);
        check_value(names[i], "latency", 32'(e.lat), 32'(lat));
        check_value(names[i], "stall_prev", 32'd0, 32'(stall_prev));
        check_value(names[i], "reg write", 32'(e.exp_wr), 32'(exec_is_reg_write));
        if (e.exp_wr) begin
            check_value(names[i], "rd", 32'(e.rd), 32'(exec_reg_write_sel));
            check_value(names[i], "result", e.exp_result, exec_result);
        end
        check_value(names[i], "exception", 32'(e.exp_exc), 32'(exec_exception));
        if (e.exp_exc) begin
            check_value(names[i], "cause", 32'(e.exp_cause), 32'(exec_trap_cause));
        end
        check_value(names[i], "taken", 32'(e.exp_taken), 32'(exec_is_taken_branch));
        if (e.exp_taken) begin
            check_value(names[i], "target", e.exp_target, exec_branch_target);
        end
        check_value(names[i], "flush", 32'(e.exp_taken || e.exp_exc), 32'(exec_pipeline_flush));
        if (!discarded) begin
            check_value(names[i], "next addr", e.pc + 32'd4, exec_instruction_next_addr);
        end
    endtask

    initial begin
        int n;
        int lat;
        void'($urandom(86));
        rst = 1'b1;
        prev_stalled = 1'b1; // No instruction from decode yet
        decode_exception = 1'b0;
        decode_trap_cause = '0;
        decode_is_jump = 1'b0;
        decode_is_reg_write = 1'b0;
        decode_instruction_addr = '0;
        decode_instruction_next_addr = '0;
        opcode = '0;
        rd = '0;
        funct3 = '0;
        rs1 = '0;
        rs2 = '0;
        funct7 = '0;
        decode_rs1_data = '0;
        decode_rs2_data = '0;
        i_imm = '0;
        s_imm = '0;
        b_imm = '0;
        u_imm = '0;
        j_imm = '0;
        build_table();
        n = tests.size();
        max_cycles = n * 8 + 50;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n; i++) begin
            if (!tests[i].chain) begin
                @(posedge clk);
                drive_entry(i);
            end
            @(posedge clk); // Accept edge
            if (i + 1 < n && tests[i + 1].chain) begin
                drive_entry(i + 1);
            end else begin
                prev_stalled <= 1'b1;
            end
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
                if (lat < tests[i].lat) begin
                    // Decode is held while the access is still in flight
                    check_value(names[i], "stall_prev", 32'd1, 32'(stall_prev));
                end
            end while (stall_next);
            check_entry(i, lat);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire prev_stalled,
    output logic stall_prev,
    output logic stall_next,

    input wire decode_exception,
    input wire [3:0] decode_trap_cause,
    input wire decode_is_jump,
    input wire decode_is_reg_write,
    input wire [alen-1:0] decode_instruction_addr,
    input wire [alen-1:0] decode_instruction_next_addr,
    input wire [4:0] opcode,
    input wire [4:0] rd,
    input wire [2:0] funct3,
    input wire [4:0] rs1,
    input wire [4:0] rs2,
    input wire [xlen-1:0] decode_rs1_data,
    input wire [xlen-1:0] decode_rs2_data,
    input wire [6:0] funct7,
    input wire [31:20] i_imm,
    input wire [11:0] s_imm,
    input wire [12:1] b_imm,
    input wire [31:12] u_imm,
    input wire [20:1] j_imm,

    output logic exec_exception,
    output logic [3:0] exec_trap_cause,
    output logic exec_is_taken_branch,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output logic [xlen-1:0] exec_result,
    output logic [alen-1:0] exec_branch_target,
    output logic [alen-1:0] exec_instruction_next_addr,
    output logic exec_pipeline_flush
);

    logic req;
    logic we;
    logic ack;
    logic [7:0] word_addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;
    logic [3:0] wmask;

    exec u_exec (.*);

    data_ram u_ram (.*);

endmodule

`default_nettype wire

// File: exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire prev_stalled,
    output logic stall_prev,
    output logic stall_next,

    input wire decode_exception,
    input wire [3:0] decode_trap_cause,
    input wire decode_is_jump,
    input wire decode_is_reg_write,
    input wire [alen-1:0] decode_instruction_addr,
    input wire [alen-1:0] decode_instruction_next_addr,
    input wire [4:0] opcode,
    input wire [4:0] rd,
    input wire [2:0] funct3,
    input wire [4:0] rs1,
    input wire [4:0] rs2,
    input wire [xlen-1:0] decode_rs1_data,
    input wire [xlen-1:0] decode_rs2_data,
    input wire [6:0] funct7,
    input wire [31:20] i_imm,
    input wire [11:0] s_imm,
    input wire [12:1] b_imm,
    input wire [31:12] u_imm,
    input wire [20:1] j_imm,

    output logic exec_exception,
    output logic [3:0] exec_trap_cause,
    output logic exec_is_taken_branch,
    output logic exec_is_reg_write,
    output logic [4:0] exec_reg_write_sel,
    output logic [xlen-1:0] exec_result,
    output logic [alen-1:0] exec_branch_target,
    output logic [alen-1:0] exec_instruction_next_addr, // Address after this instruction
    output logic exec_pipeline_flush,

    output logic req,
    output logic we,
    output logic [7:0] word_addr,
    output logic [xlen-1:0] wdata,
    output logic [3:0] wmask,
    input wire ack,
    input wire [xlen-1:0] rdata
);

    logic busy;
    logic reg_write_q;
    logic dec_exc_buf;
    logic [3:0] dec_cause_buf;
    logic offered;
    logic accept;
    logic input_valid;
    logic any_valid;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    logic int_start, int_output_valid;
    logic [xlen-1:0] int_result;
    logic branch_start, branch_output_valid, branch_taken, branch_exception;
    logic mispredict_detected;
    logic [3:0] branch_trap_cause;
    logic [alen-1:0] branch_target;
    logic [xlen-1:0] branch_result;
    logic mem_start, mem_output_valid, mem_exception;
    logic [3:0] mem_trap_cause;
    logic [xlen-1:0] mem_result;
    logic do_load, do_store, lsu_busy, lsu_done, access_fault;
    logic [alen-1:0] lsu_addr;
    logic [xlen-1:0] store_data, load_data;
    logic [3:0] store_mask;

    // Bypass of the result leaving this stage in the same cycle
    assign rs1_data = (exec_is_reg_write && exec_reg_write_sel == rs1) ? exec_result : decode_rs1_data;
    assign rs2_data = (exec_is_reg_write && exec_reg_write_sel == rs2) ? exec_result : decode_rs2_data;

    assign offered = !prev_stalled && !stall_prev;
    assign accept = offered && !exec_pipeline_flush;
    assign input_valid = accept && !decode_exception;

    assign branch_start = input_valid && (opcode[4] || decode_is_jump);
    assign int_start = input_valid && !opcode[4] && opcode[2];
    assign mem_start = input_valid && !opcode[4] && !opcode[2];

    exec_int u_int (.*, .instruction_addr(decode_instruction_addr));
    exec_branch u_branch (.*, .instruction_addr(decode_instruction_addr),
        .instruction_next_addr(decode_instruction_next_addr));
    exec_mem u_mem (.*, .addr(lsu_addr));
    load_store u_lsu (
        .clk, .rst, .do_load, .do_store, .addr(lsu_addr), .store_data, .store_mask,
        .busy(lsu_busy), .done(lsu_done), .access_fault, .load_data,
        .req, .we, .word_addr, .wdata, .wmask, .ack, .rdata
    );

    assign any_valid = int_output_valid || branch_output_valid || mem_output_valid;
    assign stall_next = busy && !any_valid;
    assign stall_prev = busy && stall_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            reg_write_q <= 1'b0;
            dec_exc_buf <= 1'b0;
        end else begin
            dec_exc_buf <= accept && decode_exception;
            if (input_valid) begin
                busy <= 1'b1;
                reg_write_q <= decode_is_reg_write && rd != 5'd0; // x0 is never written
            end else if (!stall_next) begin
                busy <= 1'b0;
                reg_write_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (input_valid) begin
            exec_reg_write_sel <= rd;
        end
        if (accept) begin
            dec_cause_buf <= decode_trap_cause;
            exec_instruction_next_addr <= decode_instruction_next_addr;
        end
    end

    // One-hot AND-OR merge of the unit outputs
    assign exec_result = ({xlen{int_output_valid}} & int_result)
        | ({xlen{branch_output_valid}} & branch_result)
        | ({xlen{mem_output_valid}} & mem_result);
    assign exec_exception = (branch_output_valid && branch_exception)
        || (mem_output_valid && mem_exception) || dec_exc_buf;
    assign exec_trap_cause = ({4{branch_output_valid}} & branch_trap_cause)
        | ({4{mem_output_valid}} & mem_trap_cause)
        | ({4{dec_exc_buf}} & dec_cause_buf);

    assign exec_is_reg_write = reg_write_q && any_valid && !exec_exception;
    assign exec_is_taken_branch = branch_output_valid && branch_taken;
    assign exec_branch_target = branch_target;
    assign exec_pipeline_flush = mispredict_detected || exec_exception;

    a_one_result: assert property (@(posedge clk) disable iff (rst)
        $onehot0({int_output_valid, branch_output_valid, mem_output_valid, dec_exc_buf}));

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire req,
    input wire we,
    input wire [7:0] word_addr,
    input wire [xlen-1:0] wdata,
    input wire [3:0] wmask,
    output logic ack,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0] mem [ram_words];

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (wmask[i]) begin
                        mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
            rdata <= mem[word_addr]; // Old contents on a write
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(req));

endmodule

`default_nettype wire

// File: load_store.sv
`timescale 1ns/1ps
`default_nettype none

module load_store import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire do_load,
    input wire do_store,
    input wire [alen-1:0] addr,
    input wire [xlen-1:0] store_data,
    input wire [3:0] store_mask,
    output logic busy,
    output logic done,
    output logic access_fault,
    output logic [xlen-1:0] load_data,
    output logic req,
    output logic we,
    output logic [7:0] word_addr,
    output logic [xlen-1:0] wdata,
    output logic [3:0] wmask,
    input wire ack,
    input wire [xlen-1:0] rdata
);

    typedef enum logic {st_idle, st_wait} state_t;

    state_t state;
    logic in_range;

    assign in_range = addr < alen'(ram_words * 4);
    assign busy = state == st_wait;

    // The request leaves in the same cycle as the issue pulse
    assign req = (do_load || do_store) && in_range;
    assign we = do_store;
    assign word_addr = addr[$clog2(ram_words)+1:2];
    assign wdata = store_data;
    assign wmask = store_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            done <= 1'b0;
            access_fault <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_wait;
                    end else if (do_load || do_store) begin
                        done <= 1'b1; // Out of range, no RAM access
                        access_fault <= 1'b1;
                    end
                end
                default: begin
                    if (ack) begin
                        state <= st_idle;
                        done <= 1'b1;
                        access_fault <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && ack) begin
            load_data <= rdata;
        end
    end

    a_no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        (do_load || do_store) |-> !busy);

endmodule

`default_nettype wire

// File: exec_mem.sv
`timescale 1ns/1ps
`default_nettype none

module exec_mem import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire mem_start,
    input wire [4:0] opcode,
    input wire [2:0] funct3,
    input wire [xlen-1:0] rs1_data,
    input wire [xlen-1:0] rs2_data,
    input wire [31:20] i_imm,
    input wire [11:0] s_imm,
    output logic mem_output_valid,
    output logic mem_exception,
    output logic [3:0] mem_trap_cause,
    output logic [xlen-1:0] mem_result,
    output logic do_load,
    output logic do_store,
    output logic [alen-1:0] addr,
    output logic [xlen-1:0] store_data,
    output logic [3:0] store_mask,
    input wire lsu_busy,
    input wire lsu_done,
    input wire access_fault,
    input wire [xlen-1:0] load_data
);

    logic is_store;
    logic [alen-1:0] ea;
    logic misaligned;
    logic [3:0] mask_comb;
    logic misaligned_valid;
    logic store_q;
    logic [2:0] funct3_q;
    logic [1:0] offset_q;
    logic [xlen-1:0] lane;

    assign is_store = opcode == op_store;
    assign ea = rs1_data + (is_store ? {{20{s_imm[11]}}, s_imm} : {{20{i_imm[31]}}, i_imm});
    assign misaligned = (funct3[1:0] == 2'b01 && ea[0]) || (funct3[1:0] == 2'b10 && ea[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b00: mask_comb = 4'b0001 << ea[1:0];
            2'b01: mask_comb = 4'b0011 << ea[1:0];
            default: mask_comb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            misaligned_valid <= 1'b0;
            do_load <= 1'b0;
            do_store <= 1'b0;
        end else begin
            misaligned_valid <= mem_start && misaligned;
            do_load <= mem_start && !misaligned && !is_store && !lsu_busy;
            do_store <= mem_start && !misaligned && is_store && !lsu_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            addr <= ea;
            store_data <= rs2_data << {ea[1:0], 3'b000}; // Move data into its byte lanes
            store_mask <= mask_comb;
            store_q <= is_store;
            funct3_q <= funct3;
            offset_q <= ea[1:0];
        end
    end

    assign lane = load_data >> {offset_q, 3'b000};

    always_comb begin
        case (funct3_q)
            f3_byte: mem_result = {{24{lane[7]}}, lane[7:0]};
            f3_half: mem_result = {{16{lane[15]}}, lane[15:0]};
            f3_byte_u: mem_result = {24'b0, lane[7:0]};
            f3_half_u: mem_result = {16'b0, lane[15:0]};
            default: mem_result = lane;
        endcase
    end

    // Load and store results come straight from the registered LSU completion
    assign mem_output_valid = misaligned_valid || lsu_done;
    assign mem_exception = misaligned_valid || (lsu_done && access_fault);

    always_comb begin
        if (misaligned_valid) begin
            mem_trap_cause = store_q ? cause_store_misaligned : cause_load_misaligned;
        end else begin
            mem_trap_cause = store_q ? cause_store_fault : cause_load_fault;
        end
    end

endmodule

`default_nettype wire

// File: exec_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exec_branch import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire branch_start,
    input wire [4:0] opcode,
    input wire [2:0] funct3,
    input wire [xlen-1:0] rs1_data,
    input wire [xlen-1:0] rs2_data,
    input wire [12:1] b_imm,
    input wire [20:1] j_imm,
    input wire [31:20] i_imm,
    input wire [alen-1:0] instruction_addr,
    input wire [alen-1:0] instruction_next_addr,
    output logic branch_output_valid,
    output logic branch_taken,
    output logic branch_exception,
    output logic [3:0] branch_trap_cause,
    output logic [alen-1:0] branch_target,
    output logic [xlen-1:0] branch_result,
    output logic mispredict_detected
);

    logic cond;
    logic taken;
    logic misaligned;
    logic [alen-1:0] target;

    always_comb begin
        case (funct3)
            f3_beq: cond = rs1_data == rs2_data;
            f3_bne: cond = rs1_data != rs2_data;
            f3_blt: cond = $signed(rs1_data) < $signed(rs2_data);
            f3_bge: cond = $signed(rs1_data) >= $signed(rs2_data);
            f3_bltu: cond = rs1_data < rs2_data;
            f3_bgeu: cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal: target = instruction_addr + {{11{j_imm[20]}}, j_imm, 1'b0};
            op_jalr: target = (rs1_data + {{20{i_imm[31]}}, i_imm}) & ~32'd1;
            default: target = instruction_addr + {{19{b_imm[12]}}, b_imm, 1'b0};
        endcase
    end

    assign taken = (opcode == op_jal) || (opcode == op_jalr) || ((opcode == op_branch) && cond);
    assign misaligned = taken && (target[1:0] != 2'b00);
    assign branch_trap_cause = cause_instr_misaligned;

    // Not-taken prediction, so every taken branch redirects the front end
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_output_valid <= 1'b0;
            branch_taken <= 1'b0;
            mispredict_detected <= 1'b0;
            branch_exception <= 1'b0;
        end else begin
            branch_output_valid <= branch_start;
            branch_taken <= branch_start && taken && !misaligned;
            mispredict_detected <= branch_start && taken && !misaligned;
            branch_exception <= branch_start && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_start) begin
            branch_target <= target;
            branch_result <= instruction_next_addr; // Link value
        end
    end

endmodule

`default_nettype wire

// File: exec_int.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int import exec_pkg::*; (
    input wire clk,
    input wire rst,
    input wire int_start,
    input wire [4:0] opcode,
    input wire [2:0] funct3,
    input wire [6:0] funct7,
    input wire [xlen-1:0] rs1_data,
    input wire [xlen-1:0] rs2_data,
    input wire [31:20] i_imm,
    input wire [31:12] u_imm,
    input wire [alen-1:0] instruction_addr,
    output logic int_output_valid,
    output logic [xlen-1:0] int_result
);

    logic [xlen-1:0] operand_b;
    logic [4:0] shamt;
    logic is_sub;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result_comb;

    assign operand_b = (opcode == op_op) ? rs2_data : {{20{i_imm[31]}}, i_imm};
    assign shamt = operand_b[4:0];
    assign is_sub = (opcode == op_op) && funct7[5]; // OP-IMM has no subtract form

    always_comb begin
        case (funct3)
            3'b000: alu_out = is_sub ? rs1_data - operand_b : rs1_data + operand_b;
            3'b001: alu_out = rs1_data << shamt;
            3'b010: alu_out = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            3'b011: alu_out = {31'b0, rs1_data < operand_b};
            3'b100: alu_out = rs1_data ^ operand_b;
            3'b101: begin
                // Bit 30 selects the arithmetic shift in both forms
                if (funct7[5]) begin
                    alu_out = $unsigned($signed(rs1_data) >>> shamt);
                end else begin
                    alu_out = rs1_data >> shamt;
                end
            end
            3'b110: alu_out = rs1_data | operand_b;
            default: alu_out = rs1_data & operand_b;
        endcase
    end

    always_comb begin
        case (opcode)
            op_lui: result_comb = {u_imm, 12'b0};
            op_auipc: result_comb = instruction_addr + {u_imm, 12'b0};
            default: result_comb = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            int_output_valid <= 1'b0;
        end else begin
            int_output_valid <= int_start;
        end
    end

    always_ff @(posedge clk) begin
        if (int_start) begin
            int_result <= result_comb;
        end
    end

endmodule

`default_nettype wire

// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int unsigned xlen = 32;
    localparam int unsigned alen = 32;
    localparam int unsigned ilen = 32;
    localparam int unsigned ram_words = 256;

    // Opcodes are instruction bits 6 to 2
    localparam logic [4:0] op_load = 5'b00000;
    localparam logic [4:0] op_store = 5'b01000;
    localparam logic [4:0] op_op = 5'b01100;
    localparam logic [4:0] op_op_imm = 5'b00100;
    localparam logic [4:0] op_lui = 5'b01101;
    localparam logic [4:0] op_auipc = 5'b00101;
    localparam logic [4:0] op_branch = 5'b11000;
    localparam logic [4:0] op_jal = 5'b11011;
    localparam logic [4:0] op_jalr = 5'b11001;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_byte = 3'b000;
    localparam logic [2:0] f3_half = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [3:0] cause_instr_misaligned = 4'd0;
    localparam logic [3:0] cause_illegal = 4'd2;
    localparam logic [3:0] cause_load_misaligned = 4'd4;
    localparam logic [3:0] cause_load_fault = 4'd5;
    localparam logic [3:0] cause_store_misaligned = 4'd6;
    localparam logic [3:0] cause_store_fault = 4'd7;

endpackage

`default_nettype wire
